/* hdl/codec_ctrl_macros.svh */
// Codec control constants
`ifndef CODEC_CTRL_MACROS_SVH
`define CODEC_CTRL_MACROS_SVH

// Write queue size in frames
`define CODEC_FIFO_DEPTH 16

// Power-up table entries, one per codec register from 0x00
`define CODEC_INIT_LEN 20

// Host command addresses
`define CODEC_ADDR_TXGAIN 6'h09
`define CODEC_ADDR_RXGAIN 6'h0a
`define CODEC_ADDR_WRITE  6'h3b

// Data bits 31..24 of a generic write must carry this
`define CODEC_WRITE_SEL 8'h06

// Codec registers behind the gain commands
`define CODEC_REG_TXGAIN 5'h0a
`define CODEC_REG_RXGAIN 5'h09

`endif

/* hdl/codec_ctrl_pkg.sv */
// Codec control types
`default_nettype none

package codec_ctrl_pkg;

  typedef logic [4:0]  reg_addr_t; // Codec register address
  typedef logic [7:0]  reg_val_t;  // Codec register value
  typedef logic [3:0]  tx_gain_t;
  typedef logic [6:0]  rx_gain_t;
  typedef logic [5:0]  cmd_addr_t; // Host command address
  typedef logic [31:0] cmd_data_t;

  // One serial write, shifted out MSB first
  typedef struct packed {
    logic [2:0] hdr;  // Write flag and width, all zero
    reg_addr_t  addr;
    reg_val_t   val;
  } spi_frame_t;

  // Host command presented with a strobe
  typedef struct packed {
    cmd_addr_t addr;
    cmd_data_t data;
  } host_cmd_t;

  // Decoder FSM
  typedef enum logic [2:0] {
    DEC_INIT,   // Walking the power-up table
    DEC_IDLE,   // Waiting for host commands
    DEC_TXGAIN,
    DEC_RXGAIN,
    DEC_WRITE
  } dec_state_t;

  // Serializer FSM
  typedef enum logic [1:0] {
    SER_IDLE,
    SER_SHIFT,  // sen_n low, bits going out
    SER_GAP     // One cycle with sen_n high
  } ser_state_t;

endpackage

`default_nettype wire

/* hdl/codec_cmd_decoder.sv */
// Codec command decoder
`timescale 1ns/10ps
`default_nettype none
`include "codec_ctrl_macros.svh"

module codec_cmd_decoder (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire codec_ctrl_pkg::host_cmd_t cmd,
  input  wire logic                    cmd_strobe,
  output logic                         cmd_ack,
  output logic                         init_done,
  output codec_ctrl_pkg::spi_frame_t   frame,
  output logic                         push
);

  codec_ctrl_pkg::dec_state_t state;
  codec_ctrl_pkg::reg_addr_t  init_idx;  // Table index doubles as register address
  codec_ctrl_pkg::reg_val_t   init_val;
  logic                       init_wr;
  codec_ctrl_pkg::tx_gain_t   tx_gain;
  codec_ctrl_pkg::rx_gain_t   rx_gain;
  codec_ctrl_pkg::tx_gain_t   new_tx;
  codec_ctrl_pkg::rx_gain_t   new_rx;
  codec_ctrl_pkg::reg_addr_t  wr_addr;   // Captured generic write
  codec_ctrl_pkg::reg_val_t   wr_val;
  logic [5:0]                 rx_code;
  logic                       is_tx, is_rx, is_wr;

  // Power-up table, {write flag, value} per register
  function automatic logic [8:0] init_entry(input codec_ctrl_pkg::reg_addr_t a);
    case (a)
      5'h00:   return {1'b0, 8'h80}; // 4-wire port, already default
      5'h06:   return {1'b1, 8'h54}; // Second clock output off
      5'h07:   return {1'b1, 8'h30}; // DC offset cal, RX filter on
      5'h08:   return {1'b0, 8'h4b};
      5'h09:   return {1'b1, 8'h40}; // RX gain for the reset gain of 0x40
      5'h0a:   return {1'b1, 8'h40}; // TX gain for the reset gain of 0
      5'h0b:   return {1'b1, 8'h00}; // No PGA gain
      5'h0c:   return {1'b1, 8'h43}; // TX format and interpolation
      5'h0d:   return {1'b1, 8'h03}; // RX format
      5'h0e:   return {1'b1, 8'h81}; // IAMP setup
      5'h10:   return {1'b1, 8'h80}; // TX gain select
      5'h11:   return {1'b1, 8'h00};
      5'h12:   return {1'b1, 8'h00};
      default: return {1'b0, 8'h00}; // Left at codec default
    endcase
  endfunction

  assign {init_wr, init_val} = init_entry(init_idx);

  // Command recognition
  assign is_tx = (cmd.addr == `CODEC_ADDR_TXGAIN);
  assign is_rx = (cmd.addr == `CODEC_ADDR_RXGAIN);
  assign is_wr = (cmd.addr == `CODEC_ADDR_WRITE) && (cmd.data[31:24] == `CODEC_WRITE_SEL);
  assign new_tx = cmd.data[31:28];
  assign new_rx = cmd.data[6:0];

  // RX gain to register code, three ranges on bits 6 and 5
  always_comb begin
    if (rx_gain[6])
      rx_code = rx_gain[5:0];
    else if (rx_gain[5])
      rx_code = ~rx_gain[5:0];
    else
      rx_code = {1'b1, rx_gain[4:0]};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= codec_ctrl_pkg::DEC_INIT;
      init_idx  <= '0;
      init_done <= 1'b0;
      cmd_ack   <= 1'b0;
      push      <= 1'b0;
      tx_gain   <= 4'h0;
      rx_gain   <= 7'h40;
    end else begin
      cmd_ack <= 1'b0; // Single-cycle pulses
      push    <= 1'b0;
      case (state)
        codec_ctrl_pkg::DEC_INIT: begin
          push     <= init_wr;        // Only flagged entries go out
          init_idx <= init_idx + 5'd1;
          if (init_idx == 5'(`CODEC_INIT_LEN - 1)) begin
            state     <= codec_ctrl_pkg::DEC_IDLE;
            init_done <= 1'b1;
          end
        end
        codec_ctrl_pkg::DEC_IDLE: begin
          if (cmd_strobe) begin
            cmd_ack <= is_tx | is_rx | is_wr;
            if (is_tx && new_tx != tx_gain) begin
              tx_gain <= new_tx;
              state   <= codec_ctrl_pkg::DEC_TXGAIN;
            end
            if (is_rx && new_rx != rx_gain) begin
              rx_gain <= new_rx;
              state   <= codec_ctrl_pkg::DEC_RXGAIN;
            end
            if (is_wr)
              state <= codec_ctrl_pkg::DEC_WRITE;
          end
        end
        codec_ctrl_pkg::DEC_TXGAIN,
        codec_ctrl_pkg::DEC_RXGAIN,
        codec_ctrl_pkg::DEC_WRITE: begin
          push  <= 1'b1; // Frame built this cycle
          state <= codec_ctrl_pkg::DEC_IDLE;
        end
        default: state <= codec_ctrl_pkg::DEC_IDLE;
      endcase
    end
  end

  // Frame payload and write capture
  always_ff @(posedge clk) begin
    frame.hdr <= 3'b000; // Write, one byte
    if (state == codec_ctrl_pkg::DEC_IDLE && cmd_strobe) begin
      wr_addr <= cmd.data[20:16];
      wr_val  <= cmd.data[7:0];
    end
    case (state)
      codec_ctrl_pkg::DEC_INIT: begin
        frame.addr <= init_idx;
        frame.val  <= init_val;
      end
      codec_ctrl_pkg::DEC_TXGAIN: begin
        frame.addr <= `CODEC_REG_TXGAIN;
        frame.val  <= {4'h4, tx_gain};  // 0x40 plus gain
      end
      codec_ctrl_pkg::DEC_RXGAIN: begin
        frame.addr <= `CODEC_REG_RXGAIN;
        frame.val  <= {2'b01, rx_code};
      end
      codec_ctrl_pkg::DEC_WRITE: begin
        frame.addr <= wr_addr;
        frame.val  <= wr_val;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/spi_write_fifo.sv */
// Serial frame write queue
`timescale 1ns/10ps
`default_nettype none
`include "codec_ctrl_macros.svh"

module spi_write_fifo #(
  parameter int DEPTH = `CODEC_FIFO_DEPTH
) (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire codec_ctrl_pkg::spi_frame_t wr_frame,
  input  wire logic                       push,
  input  wire logic                       pop,
  output codec_ctrl_pkg::spi_frame_t      rd_frame,
  output logic                            empty,
  output logic                            overflow
);

  localparam int AW = $clog2(DEPTH);

  codec_ctrl_pkg::spi_frame_t mem [DEPTH];
  logic [AW-1:0] wr_ptr, rd_ptr;
  logic [AW:0]   count;      // One extra bit to hold DEPTH
  logic          full;
  logic          wr_en, rd_en;

  assign full  = (count == (AW+1)'(DEPTH));
  assign empty = (count == '0);
  assign wr_en = push & ~full;  // Full queue drops the frame
  assign rd_en = pop & ~empty;

  assign rd_frame = mem[rd_ptr]; // Show-ahead head

  // Storage
  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_ptr] <= wr_frame;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (wr_en)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ; // Both or neither
      endcase
      if (push && full)
        overflow <= 1'b1; // Sticky until reset
    end
  end

endmodule

`default_nettype wire

/* hdl/spi_serializer.sv */
// Codec serial port shifter
`timescale 1ns/10ps
`default_nettype none

module spi_serializer (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire codec_ctrl_pkg::spi_frame_t frame,
  input  wire logic                       empty,
  output logic                            pop,
  output logic                            sclk,
  output logic                            sdio,
  output logic                            sen_n
);

  codec_ctrl_pkg::ser_state_t state;
  logic [15:0] shreg;   // Frame being sent, MSB on the pin
  logic [3:0]  bit_cnt; // Bits left after the current one

  // Take the head as soon as the port is free
  assign pop  = (state == codec_ctrl_pkg::SER_IDLE) && !empty;
  assign sdio = shreg[15];

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= codec_ctrl_pkg::SER_IDLE;
      shreg   <= '0;   // Holds sdio low out of reset
      bit_cnt <= '0;
      sclk    <= 1'b0;
      sen_n   <= 1'b1;
    end else begin
      case (state)
        codec_ctrl_pkg::SER_IDLE: begin
          sclk <= 1'b0;
          if (pop) begin
            shreg   <= frame;
            bit_cnt <= 4'd15;
            sen_n   <= 1'b0;  // MSB is on sdio with enable
            state   <= codec_ctrl_pkg::SER_SHIFT;
          end
        end
        codec_ctrl_pkg::SER_SHIFT: begin
          if (!sclk) begin
            sclk <= 1'b1;     // Codec samples on this edge
          end else begin
            sclk    <= 1'b0;
            shreg   <= {shreg[14:0], 1'b0}; // Next bit while sclk low
            bit_cnt <= bit_cnt - 4'd1;
            if (bit_cnt == 4'd0) begin
              sen_n <= 1'b1;
              state <= codec_ctrl_pkg::SER_GAP;
            end
          end
        end
        codec_ctrl_pkg::SER_GAP: begin
          state <= codec_ctrl_pkg::SER_IDLE; // Enable stays high here
        end
        default: begin
          state <= codec_ctrl_pkg::SER_IDLE;
          sen_n <= 1'b1;
          sclk  <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/codec_ctrl_top.sv */
// Codec control top level
`timescale 1ns/10ps
`default_nettype none

module codec_ctrl_top (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire codec_ctrl_pkg::host_cmd_t cmd,
  input  wire logic                      cmd_strobe,
  output logic                           cmd_ack,
  output logic                           init_done,
  output logic                           overflow,
  output logic                           sclk,
  output logic                           sdio,
  output logic                           sen_n
);

  codec_ctrl_pkg::spi_frame_t wr_frame; // Decoder to queue
  codec_ctrl_pkg::spi_frame_t rd_frame; // Queue head to shifter
  logic push, pop, empty;

  // Producer for table and host frames
  codec_cmd_decoder u_decoder (
    .clk        (clk),
    .rst        (rst),
    .cmd        (cmd),
    .cmd_strobe (cmd_strobe),
    .cmd_ack    (cmd_ack),
    .init_done  (init_done),
    .frame      (wr_frame),
    .push       (push)
  );

  spi_write_fifo u_fifo (
    .clk      (clk),
    .rst      (rst),
    .wr_frame (wr_frame),
    .push     (push),
    .pop      (pop),
    .rd_frame (rd_frame),
    .empty    (empty),
    .overflow (overflow)
  );

  // Pin driver
  spi_serializer u_serializer (
    .clk   (clk),
    .rst   (rst),
    .frame (rd_frame),
    .empty (empty),
    .pop   (pop),
    .sclk  (sclk),
    .sdio  (sdio),
    .sen_n (sen_n)
  );

endmodule

`default_nettype wire

/* verif/codec_ctrl_asserts.sv */
// Serial port and queue checks
`timescale 1ns/10ps
`default_nettype none

module codec_ctrl_asserts (
  input wire logic clk,
  input wire logic rst,
  input wire logic sclk,
  input wire logic sdio,
  input wire logic sen_n,
  input wire logic pop,
  input wire logic empty
);

  int unsigned fail_cnt = 0; // Summed into the testbench summary

  // Gap cycle with enable high before the next frame
  gap_held: assert property (@(posedge clk) disable iff (rst) $rose(sen_n) |=> sen_n)
  else begin
    fail_cnt++;
    $error("Enable high for less than one cycle between frames");
  end

  // No clock pulses outside a frame
  sclk_idle: assert property (@(posedge clk) disable iff (rst) sen_n |-> !sclk)
  else begin
    fail_cnt++;
    $error("sclk high while sen_n is high");
  end

  // Codec samples on the rising sclk edge
  sdio_stable: assert property (@(posedge clk) disable iff (rst) $changed(sdio) |-> !sclk)
  else begin
    fail_cnt++;
    $error("sdio changed while sclk high");
  end

  pop_valid: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
  else begin
    fail_cnt++;
    $error("Pop from an empty queue");
  end

endmodule

`default_nettype wire

/* verif/codec_ctrl_tb.sv */
// Codec control testbench
`timescale 1ns/10ps
`default_nettype none
`include "codec_ctrl_macros.svh"

module codec_ctrl_tb;

  localparam int N_FRAMES   = 59; // Upper bound of frames over all tests
  localparam int N_CMDS     = 51;
  localparam int MAX_CYCLES = N_FRAMES * 33 + N_CMDS * 4 + 500;

  logic clk = 1'b0;
  logic rst;
  codec_ctrl_pkg::host_cmd_t  cmd;
  logic cmd_strobe;
  logic cmd_ack, init_done, overflow, sclk, sdio, sen_n;
  codec_ctrl_pkg::spi_frame_t exp_q[$]; // Reference stream
  codec_ctrl_pkg::spi_frame_t rx_q[$];  // Seen on the pins
  codec_ctrl_pkg::tx_gain_t   ref_tx;   // Model of the stored gains
  codec_ctrl_pkg::rx_gain_t   ref_rx;
  logic [15:0] lfsr = 16'd22;
  logic [15:0] mon_shift;
  int mon_bits;
  int err_cnt = 0;
  int cycles = 0;

  codec_ctrl_top DUT (
    .clk(clk), .rst(rst), .cmd(cmd), .cmd_strobe(cmd_strobe), .cmd_ack(cmd_ack),
    .init_done(init_done), .overflow(overflow), .sclk(sclk), .sdio(sdio), .sen_n(sen_n)
  );

  bind spi_serializer codec_ctrl_asserts u_asserts (
    .clk(clk), .rst(rst), .sclk(sclk), .sdio(sdio), .sen_n(sen_n), .pop(pop), .empty(empty)
  );

  always #50 clk = ~clk; // 100 ns period

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout, expected frames not seen within %0d cycles", MAX_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  // Serial port monitor, one frame per enable low
  always @(negedge sen_n) begin
    mon_bits = 0;
    mon_shift = '0;
    while (sen_n === 1'b0) begin
      @(posedge sclk or posedge sen_n);
      if (sen_n === 1'b0) begin
        mon_shift = {mon_shift[14:0], sdio}; // MSB first
        mon_bits++;
      end
    end
    if (mon_bits != 16) begin
      err_cnt++;
      $display("Serial frame at %0t had %0d clock rises instead of 16", $time, mon_bits);
    end
    rx_q.push_back(codec_ctrl_pkg::spi_frame_t'(mon_shift));
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic codec_ctrl_pkg::spi_frame_t make_frame(
    input codec_ctrl_pkg::reg_addr_t a, input codec_ctrl_pkg::reg_val_t v);
    return {3'b000, a, v};
  endfunction

  // RX gain register value from the three gain ranges
  function automatic codec_ctrl_pkg::reg_val_t rx_value(input codec_ctrl_pkg::rx_gain_t g);
    logic [5:0] code;
    if (g[6])
      code = g[5:0];
    else if (g[5])
      code = ~g[5:0];
    else
      code = {1'b1, g[4:0]};
    return 8'h40 + code;
  endfunction

  task automatic check_frame(input string name, input codec_ctrl_pkg::spi_frame_t exp,
                             input codec_ctrl_pkg::spi_frame_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_cnt++;
      $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #5; // Drive and sample away from the edge
  endtask

  // Enable high for n cycles in a row, nothing left to shift
  task automatic wait_port_idle(input int n);
    int quiet;
    quiet = 0;
    while (quiet < n) begin
      step_cycle();
      quiet = (sen_n === 1'b1) ? quiet + 1 : 0;
    end
  endtask

  // Strobe one command, ack due exactly one cycle later
  task automatic send_cmd(input codec_ctrl_pkg::cmd_addr_t a, input codec_ctrl_pkg::cmd_data_t d,
                          input logic exp_ack);
    step_cycle();
    check_bit("cmd_ack", 1'b0, cmd_ack);
    cmd.addr = a;
    cmd.data = d;
    cmd_strobe = 1'b1;
    step_cycle();
    cmd_strobe = 1'b0;
    check_bit("cmd_ack", exp_ack, cmd_ack);
  endtask

  task automatic wr_cmd(input codec_ctrl_pkg::reg_addr_t a, input codec_ctrl_pkg::reg_val_t v);
    send_cmd(`CODEC_ADDR_WRITE, {`CODEC_WRITE_SEL, 3'b000, a, 8'h00, v}, 1'b1);
    exp_q.push_back(make_frame(a, v));
  endtask

  task automatic tx_cmd(input codec_ctrl_pkg::tx_gain_t g);
    send_cmd(`CODEC_ADDR_TXGAIN, {g, 28'h0}, 1'b1);
    if (g != ref_tx)
      exp_q.push_back(make_frame(`CODEC_REG_TXGAIN, 8'h40 + g));
    ref_tx = g;
  endtask

  task automatic rx_cmd(input codec_ctrl_pkg::rx_gain_t g);
    send_cmd(`CODEC_ADDR_RXGAIN, {25'h0, g}, 1'b1);
    if (g != ref_rx)
      exp_q.push_back(make_frame(`CODEC_REG_RXGAIN, rx_value(g)));
    ref_rx = g;
  endtask

  // Wait for the expected count and a drained port, then compare in order
  task automatic compare_stream();
    while (rx_q.size() < exp_q.size())
      step_cycle();
    wait_port_idle(4); // Longer than the gap between queued frames
    while (exp_q.size() > 0 && rx_q.size() > 0)
      check_frame("serial frame", exp_q.pop_front(), rx_q.pop_front());
    if (rx_q.size() != 0) begin
      err_cnt++;
      $display("%0d unexpected frames on the serial port", rx_q.size());
      rx_q.delete();
    end
  endtask

  task automatic power_up_table();
    logic [15:0] table_exp [11];
    table_exp = '{16'h0654, 16'h0730, 16'h0940, 16'h0a40, 16'h0b00, 16'h0c43,
                  16'h0d03, 16'h0e81, 16'h1080, 16'h1100, 16'h1200};
    repeat (10) step_cycle();
    check_bit("sen_n", 1'b1, sen_n);
    check_bit("sclk", 1'b0, sclk);
    check_bit("sdio", 1'b0, sdio);
    check_bit("cmd_ack", 1'b0, cmd_ack);
    check_bit("init_done", 1'b0, init_done);
    check_bit("overflow", 1'b0, overflow);
    rst = 1'b0;
    ref_tx = '0;
    ref_rx = 7'h40; // Reset gains
    while (init_done !== 1'b1)
      step_cycle();
    foreach (table_exp[i])
      exp_q.push_back(table_exp[i]);
    compare_stream();
  endtask

  task automatic generic_writes();
    codec_ctrl_pkg::reg_addr_t a;
    codec_ctrl_pkg::reg_val_t  v;
    for (int i = 0; i < 8; i++) begin
      a = rand_bits(5);
      v = rand_bits(8);
      wr_cmd(a, v);
    end
    send_cmd(`CODEC_ADDR_WRITE, {8'h07, 3'b000, a, 8'h00, v}, 1'b0);    // Wrong selector
    send_cmd(6'h3a, {`CODEC_WRITE_SEL, 3'b000, a, 8'h00, v}, 1'b0);     // Unknown address
    wr_cmd(a + 5'd1, ~v);
    compare_stream();
  endtask

  task automatic tx_gain_updates();
    codec_ctrl_pkg::tx_gain_t g;
    g = rand_bits(4);
    if (g == ref_tx)
      g = ~g;
    tx_cmd(g);
    tx_cmd(g);  // Same gain, ack only
    tx_cmd(g + 4'd3);
    compare_stream();
  endtask

  task automatic rx_gain_mapping();
    codec_ctrl_pkg::rx_gain_t g;
    for (int i = 0; i < 6; i++) begin
      g = rand_bits(7);
      case (i % 3)
        0:       g[6] = 1'b1;
        1:       g[6:5] = 2'b01;
        default: g[6:5] = 2'b00;
      endcase
      if (g == ref_rx)
        g[0] = ~g[0];
      rx_cmd(g);
    end
    compare_stream();
  endtask

  task automatic ack_and_queuing();
    codec_ctrl_pkg::reg_addr_t a;
    codec_ctrl_pkg::reg_val_t  v;
    a = rand_bits(5);
    v = rand_bits(8);
    wr_cmd(a, v);
    while (sen_n !== 1'b0)
      step_cycle();
    tx_cmd(ref_tx + 4'd1); // Back to back while shifting
    rx_cmd(ref_rx ^ 7'h21);
    wr_cmd(a ^ 5'h15, v + 8'd7);
    wr_cmd(a ^ 5'h0a, ~v);
    tx_cmd(ref_tx + 4'd5);
    rx_cmd(ref_rx ^ 7'h44);
    compare_stream();
    check_bit("overflow", 1'b0, overflow);
  endtask

  task automatic overflow_burst();
    codec_ctrl_pkg::reg_addr_t a;
    codec_ctrl_pkg::reg_val_t  v;
    int k;
    for (int i = 0; i < 24; i++) begin
      a = rand_bits(5);
      v = rand_bits(8);
      wr_cmd(a, v);
    end
    wait_port_idle(40); // Port idle means the queue drained
    check_bit("overflow", 1'b1, overflow);
    if (rx_q.size() < 16 || rx_q.size() >= 24) begin
      err_cnt++;
      $display("Overflow burst gave %0d frames, expected 16 to 23", rx_q.size());
    end
    // First 16 match exactly, later ones may skip dropped frames
    k = 0;
    while (rx_q.size() > 0 && exp_q.size() > 0) begin
      if (k < 16 || rx_q[0] === exp_q[0]) begin
        check_frame("serial frame", exp_q[0], rx_q.pop_front());
        k++;
      end
      exp_q.delete(0);
    end
    if (rx_q.size() != 0)
      $display("%0d frames out of command order after overflow", rx_q.size());
    err_cnt += rx_q.size();
    exp_q.delete();
  endtask

  initial begin
    rst = 1'b1;
    cmd = '0;
    cmd_strobe = 1'b0;
    power_up_table();
    generic_writes();
    tx_gain_updates();
    rx_gain_mapping();
    ack_and_queuing();
    overflow_burst();
    $display("Errors: %0d check, %0d assertion", err_cnt, DUT.u_serializer.u_asserts.fail_cnt);
    if (err_cnt == 0 && DUT.u_serializer.u_asserts.fail_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hdl
hdl/codec_ctrl_pkg.sv
hdl/codec_cmd_decoder.sv
hdl/spi_write_fifo.sv
hdl/spi_serializer.sv
hdl/codec_ctrl_top.sv
verif/codec_ctrl_asserts.sv
verif/codec_ctrl_tb.sv
